// File: Makefile
VERILATOR ?= verilator
TOP       ?= usb_spi_ctrl_ep_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+100

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
  output logic clk,
  output logic reset
);
  initial begin
    clk   = 1'b0;
    reset = 1'b1;                   // held for three rising edges
    repeat (3) @(posedge clk);
    #1 reset = 1'b0;                // same skew as other inputs
  end

  always #2 clk = ~clk;             // 4 ns period
endmodule

`default_nettype wire

// File: bench/usb_spi_ctrl_ep_chk.sv
`timescale 1ns/10ps
`default_nettype none

module usb_spi_ctrl_ep_chk (
  input logic       clk,
  input logic       reset,
  input logic       spi_clk,
  input logic       spi_csn,
  input logic       in_ep_req,
  input logic       in_ep_data_put,
  input logic       in_ep_stall,
  input logic       in_ep_acked,
  input logic [6:0] dev_addr
);
  int failures = 0;                 // polled by the testbench

  // mode 3 bus parks the clock high
  spi_idle_high: assert property (@(posedge clk) disable iff (reset) spi_csn |-> spi_clk)
    else begin
      failures = failures + 1;
      $error("spi_clk low while spi_csn is high");
    end

  put_needs_req: assert property (@(posedge clk) disable iff (reset)
                                  in_ep_data_put |-> in_ep_req)
    else begin
      failures = failures + 1;
      $error("in_ep_data_put without in_ep_req");
    end

  stall_one_cycle: assert property (@(posedge clk) disable iff (reset)
                                    in_ep_stall |=> !in_ep_stall)
    else begin
      failures = failures + 1;
      $error("in_ep_stall longer than one cycle");
    end

  // new address only after the status handshake
  addr_after_ack: assert property (@(posedge clk) disable iff (reset)
                                   $changed(dev_addr) |-> $past(in_ep_acked))
    else begin
      failures = failures + 1;
      $error("dev_addr changed without a preceding in_ep_acked");
    end
endmodule

bind usb_spi_ctrl_ep usb_spi_ctrl_ep_chk chk (
  .clk(clk), .reset(reset), .spi_clk(spi_clk), .spi_csn(spi_csn),
  .in_ep_req(in_ep_req), .in_ep_data_put(in_ep_data_put),
  .in_ep_stall(in_ep_stall), .in_ep_acked(in_ep_acked), .dev_addr(dev_addr)
);

`default_nettype wire

// File: bench/usb_spi_ctrl_ep_tb.sv
`timescale 1ns/10ps
`default_nettype none

module usb_spi_ctrl_ep_tb;
  logic       clk, reset;
  logic       out_ep_grant, out_ep_data_avail, out_ep_setup, out_ep_acked;
  logic [7:0] out_ep_data;
  logic       in_ep_grant, in_ep_data_free, in_ep_acked;
  logic       out_ep_req, out_ep_data_get, out_ep_stall;
  logic       in_ep_req, in_ep_data_put, in_ep_data_done, in_ep_stall;
  logic [7:0] in_ep_data;
  logic [6:0] dev_addr;
  logic       spi_mosi, spi_clk, spi_csn;

  logic [7:0] pkt [0:7];            // bytes of the packet being sent
  logic [7:0] wr_bytes [0:3];
  logic [7:0] rx_q [$];             // bytes put by the device
  logic       mosi_q [$];
  int         seed = 19;
  int         cycles = 0;
  int         done_cnt = 0;
  int         put_cnt = 0;

  // descriptor bytes as the host expects them
  logic [7:0] dev_desc [0:17] = '{8'd18, 8'd1, 8'h00, 8'h02, 8'hff, 8'h00, 8'h00, 8'd32,
                                  8'hc0, 8'h16, 8'hdc, 8'h05, 8'h01, 8'h00, 8'h00, 8'h00,
                                  8'h00, 8'd1};
  logic [7:0] cfg_desc [0:8]  = '{8'd9, 8'd2, 8'd18, 8'h00, 8'd1, 8'd1, 8'h00, 8'hc0, 8'd250};

  tb_clock clock_gen (.clk(clk), .reset(reset));

  usb_spi_ctrl_ep uut (.spi_miso(spi_mosi), .*);  // miso looped back from mosi

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic expect_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    assert (got === exp) else
      abort_run($sformatf("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp));
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;                             // inputs move just after the edge
  endtask

  task automatic idle_gap();
    repeat (3 + ($random(seed) & 3)) next_cycle();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // host side of the out endpoint
  ////////////////////////////////////////////////////////////////////////////
  task automatic send_packet(input logic is_setup, input int n);
    out_ep_setup = is_setup;
    for (int i = 0; i <= n; i++) begin
      out_ep_data_avail = (i < n);
      if (i > 0) out_ep_data = pkt[i-1];  // byte lags the grant by a cycle
      next_cycle();
    end
    out_ep_setup = 1'b0;
  endtask

  task automatic send_setup(input logic [7:0] bm, input logic [7:0] req,
                            input logic [15:0] val, input logic [15:0] len);
    pkt = '{bm, req, val[7:0], val[15:8], 8'h00, 8'h00, len[7:0], len[15:8]};
    send_packet(1'b1, 8);
  endtask

  task automatic wait_done();
    while (in_ep_data_done !== 1'b1) @(negedge clk);
    next_cycle();
    expect_equal("in_ep_req", in_ep_req, 0);  // nothing left to request
  endtask

  task automatic pulse_ack(input logic is_in);
    in_ep_acked  = is_in;
    out_ep_acked = !is_in;
    next_cycle();
    in_ep_acked  = 1'b0;
    out_ep_acked = 1'b0;
  endtask

  task automatic control_in(input logic [7:0] bm, input logic [7:0] req,
                            input logic [15:0] val, input logic [15:0] len);
    rx_q.delete();
    send_setup(bm, req, val, len);
    wait_done();
    pulse_ack(1'b1);                // data stage taken
    idle_gap();
    pulse_ack(1'b0);                // zero-length status out
    idle_gap();
  endtask

  // in collector, grants and frees always
  always @(negedge clk) begin
    if (in_ep_data_put && in_ep_grant) begin
      rx_q.push_back(in_ep_data);
      put_cnt++;
    end
    if (in_ep_data_done) done_cnt++;
    expect_equal("out_ep_req", out_ep_req, out_ep_data_avail);  // out side always ready
    expect_equal("out_ep_data_get", out_ep_data_get, out_ep_data_avail);
    expect_equal("out_ep_stall", out_ep_stall, 0);
    if (uut.chk.failures != 0) abort_run("a protocol assertion in the checker failed");
  end

  always @(posedge spi_clk) begin
    if (spi_csn === 1'b0) mosi_q.push_back(spi_mosi);
  end

  // whole run is a few hundred cycles
  always @(posedge clk) begin
    cycles++;
    if (cycles >= 4000) abort_run("timeout: run did not finish within 4000 cycles");
  end

  initial begin
    int first_done;
    int puts_before;
    out_ep_grant      = 1'b1;
    out_ep_data_avail = 1'b0;
    out_ep_setup      = 1'b0;
    out_ep_data       = 8'h00;
    out_ep_acked      = 1'b0;
    in_ep_grant       = 1'b1;
    in_ep_data_free   = 1'b1;
    in_ep_acked       = 1'b0;
    wait (reset === 1'b0);
    idle_gap();

    first_done = done_cnt;          // device descriptor, host asks for 64
    control_in(8'h80, 8'h06, 16'h0100, 16'd64);
    expect_equal("device descriptor length", rx_q.size(), 18);
    foreach (dev_desc[i]) expect_equal($sformatf("in_ep_data[%0d]", i), rx_q[i], dev_desc[i]);
    expect_equal("in_ep_data_done pulses", done_cnt - first_done, 1);
    control_in(8'h80, 8'h06, 16'h0200, 16'd9);  // config cut to wLength
    expect_equal("config descriptor length", rx_q.size(), 9);
    foreach (cfg_desc[i]) expect_equal($sformatf("in_ep_data[%0d]", i), rx_q[i], cfg_desc[i]);

    send_setup(8'h00, 8'h05, 16'h002a, 16'd0);  // SET_ADDRESS
    wait_done();
    expect_equal("dev_addr", dev_addr, 0);
    in_ep_acked = 1'b1;
    @(negedge clk);
    expect_equal("dev_addr", dev_addr, 0);
    next_cycle();
    in_ep_acked = 1'b0;
    expect_equal("dev_addr", dev_addr, 8'h2a);
    idle_gap();

    puts_before = put_cnt;          // qualifier gets a stall
    send_setup(8'h80, 8'h06, 16'h0600, 16'd10);
    while (in_ep_stall !== 1'b1) @(negedge clk);
    repeat (4) next_cycle();
    expect_equal("in_ep_data_put count", put_cnt - puts_before, 0);
    idle_gap();

    foreach (wr_bytes[i]) wr_bytes[i] = 8'($random(seed));
    mosi_q.delete();
    send_setup(8'h40, 8'h00, 16'h0000, 16'd4);  // vendor spi write
    idle_gap();
    foreach (wr_bytes[i]) pkt[i] = wr_bytes[i];
    send_packet(1'b0, 4);
    expect_equal("spi_csn", spi_csn, 0);
    wait_done();
    pulse_ack(1'b1);
    idle_gap();
    expect_equal("spi_csn", spi_csn, 0);        // still shifting
    control_in(8'hc0, 8'h01, 16'h0000, 16'd1);
    expect_equal("spi status length", rx_q.size(), 1);
    expect_equal("spi status while busy", rx_q[0], 1);

    while (spi_csn !== 1'b1) @(negedge clk);
    expect_equal("spi_mosi bit count", mosi_q.size(), 32);
    for (int i = 0; i < 32; i++) begin
      expect_equal($sformatf("spi_mosi bit %0d", i), mosi_q[i], wr_bytes[i/8][7 - i%8]);
    end
    next_cycle();
    control_in(8'hc0, 8'h01, 16'h0000, 16'd1);
    expect_equal("spi status length", rx_q.size(), 1);
    expect_equal("spi status when idle", rx_q[0], 0);

    control_in(8'hc0, 8'h00, 16'h0000, 16'd4);  // read back the loopback bytes
    expect_equal("spi read length", rx_q.size(), 4);
    foreach (wr_bytes[i]) expect_equal($sformatf("in_ep_data[%0d]", i), rx_q[i], wr_bytes[i]);

    if (uut.chk.failures == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      abort_run("a protocol assertion in the checker failed");
    end
  end
endmodule

`default_nettype wire

// File: list.f
verilog/usb_spi_pkg.sv
verilog/setup_if.sv
verilog/setup_decoder.sv
verilog/ctrl_xfer_fsm.sv
verilog/in_data_source.sv
verilog/spi_bridge.sv
verilog/usb_spi_ctrl_ep.sv
bench/tb_clock.sv
bench/usb_spi_ctrl_ep_chk.sv
bench/usb_spi_ctrl_ep_tb.sv

// File: verilog/ctrl_xfer_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module ctrl_xfr_fsm (
  input  logic  clk,
  input  logic  reset,
  input  logic  out_ep_data_avail,
  input  logic  out_ep_grant,
  input  logic  out_ep_setup,
  input  logic  out_ep_acked,
  input  logic  in_ep_acked,
  input  logic  all_sent,
  input  logic  stall,
  setup_if.fsm  ifc,
  output logic  out_ep_data_valid,
  output logic  in_ep_data_done
);
  usb_spi_pkg::ctrl_state_t state_next;
  logic avail_q, avail_q2;
  logic pkt_start, pkt_end;
  logic has_data;
  logic setup_end_set, zlp_set;
  logic all_sent_q, sent_rise;

  assign pkt_start = avail_q && !avail_q2;   // one cycle after avail rises
  assign pkt_end   = !avail_q && avail_q2;
  assign has_data  = ifc.length != 16'd0;

  assign in_ep_data_done = ifc.zlp || (ifc.state == usb_spi_pkg::data_in && sent_rise);

  //////////////////////////////////////////////////////////////////////////
  // stage transitions
  //////////////////////////////////////////////////////////////////////////
  always_comb begin
    state_next     = ifc.state;
    setup_end_set  = 1'b0;
    zlp_set        = 1'b0;
    ifc.status_end = 1'b0;
    case (ifc.state)
      usb_spi_pkg::idle: begin
        if (pkt_start && out_ep_setup) state_next = usb_spi_pkg::setup;
      end
      usb_spi_pkg::setup: begin
        if (pkt_end) begin
          setup_end_set = 1'b1;
          if (has_data && ifc.dir_in) begin
            state_next = usb_spi_pkg::data_in;
          end else if (has_data) begin
            state_next = usb_spi_pkg::data_out;
          end else begin
            state_next = usb_spi_pkg::status_in;  // no data stage
            zlp_set    = 1'b1;
          end
        end
      end
      usb_spi_pkg::data_in: begin
        if (stall) begin
          state_next     = usb_spi_pkg::idle;     // stalled request ends here
          ifc.status_end = 1'b1;
        end else if (in_ep_acked && all_sent) begin
          state_next = usb_spi_pkg::status_out;
        end
      end
      usb_spi_pkg::data_out: begin
        if (pkt_end) begin
          state_next = usb_spi_pkg::status_in;
          zlp_set    = 1'b1;
        end
      end
      usb_spi_pkg::status_in: begin
        if (in_ep_acked) begin
          state_next     = usb_spi_pkg::idle;
          ifc.status_end = 1'b1;
        end
      end
      usb_spi_pkg::status_out: begin
        if (out_ep_acked) begin
          state_next     = usb_spi_pkg::idle;
          ifc.status_end = 1'b1;
        end
      end
      default: state_next = usb_spi_pkg::idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ifc.state         <= usb_spi_pkg::idle;
      ifc.setup_end     <= 1'b0;
      ifc.zlp           <= 1'b0;
      avail_q           <= 1'b0;
      avail_q2          <= 1'b0;
      out_ep_data_valid <= 1'b0;
      all_sent_q        <= 1'b1;
      sent_rise         <= 1'b0;
    end else begin
      ifc.state         <= state_next;
      ifc.setup_end     <= setup_end_set;
      ifc.zlp           <= zlp_set;
      avail_q           <= out_ep_data_avail;
      avail_q2          <= avail_q;
      out_ep_data_valid <= out_ep_data_avail && out_ep_grant;  // byte lands next cycle
      all_sent_q        <= all_sent;
      sent_rise         <= all_sent && !all_sent_q;
    end
  end
endmodule

`default_nettype wire

// File: verilog/in_data_source.sv
`timescale 1ns/10ps
`default_nettype none

module in_data_source (
  input  logic                                          clk,
  input  logic                                          reset,
  setup_if.sink                                         ifc,
  input  logic                                          load,
  input  logic [usb_spi_pkg::rom_addr_w-1:0]            load_addr,
  input  logic [usb_spi_pkg::rom_addr_w-1:0]            load_len,
  input  logic                                          use_spi_buf,
  input  logic                                          in_ep_grant,
  input  logic                                          in_ep_data_free,
  input  logic [7:0]                                    spi_rd_data,
  output logic [$clog2(usb_spi_pkg::spi_buf_depth)-1:0] spi_rd_addr,
  output logic                                          all_sent,
  output logic                                          in_ep_req,
  output logic                                          in_ep_data_put,
  output logic [7:0]                                    in_ep_data
);
  localparam int aw = usb_spi_pkg::rom_addr_w;

  logic [aw-1:0] rd_addr;     // rom or spi buffer byte address
  logic [aw-1:0] sent_cnt;
  logic [aw-1:0] xfer_len;
  logic          src_spi;
  logic          byte_taken;

  // stop at whichever is shorter, source block or host wLength
  assign all_sent = (sent_cnt >= xfer_len) ||
                    ({{(16-aw){1'b0}}, sent_cnt} >= ifc.length);

  assign in_ep_req      = ifc.state == usb_spi_pkg::data_in && !all_sent;
  assign in_ep_data_put = in_ep_req && in_ep_data_free;
  assign byte_taken     = in_ep_data_put && in_ep_grant;

  assign spi_rd_addr = rd_addr[$clog2(usb_spi_pkg::spi_buf_depth)-1:0];
  assign in_ep_data  = src_spi ? spi_rd_data : usb_spi_pkg::rom_byte(rd_addr);

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_addr  <= '0;
      sent_cnt <= '0;
      xfer_len <= '0;
      src_spi  <= 1'b0;
    end else begin
      if (load) begin
        rd_addr  <= load_addr;
        sent_cnt <= '0;
        xfer_len <= load_len;
        src_spi  <= use_spi_buf;
      end else if (byte_taken) begin
        rd_addr  <= rd_addr + 1'b1;      // holds under back-pressure
        sent_cnt <= sent_cnt + 1'b1;
      end
      if (ifc.status_end) begin
        sent_cnt <= '0;
        xfer_len <= '0;                  // all_sent stays high while idle
      end
    end
  end
endmodule

`default_nettype wire

// File: verilog/setup_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module setup_decoder (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                out_ep_setup,
  input  logic                                out_ep_data_valid,
  input  logic [7:0]                          out_ep_data,
  input  logic                                busy,
  setup_if.src                                ifc,
  output logic                                load,
  output logic [usb_spi_pkg::rom_addr_w-1:0]  load_addr,
  output logic [usb_spi_pkg::rom_addr_w-1:0]  load_len,
  output logic                                use_spi_buf,
  output logic                                stall,
  output logic [6:0]                          dev_addr
);
  logic [7:0] setup_bytes [0:usb_spi_pkg::setup_len-1];
  logic [3:0] byte_cnt;
  logic       addr_pend;              // SET_ADDRESS waits for status
  logic [6:0] new_addr;

  assign ifc.req_type = setup_bytes[0][6:5];
  assign ifc.dir_in   = setup_bytes[0][7];
  assign ifc.request  = setup_bytes[1];
  assign ifc.value    = {setup_bytes[3], setup_bytes[2]};
  assign ifc.length   = {setup_bytes[7], setup_bytes[6]};

  always_ff @(posedge clk) begin
    if (out_ep_setup && out_ep_data_valid && byte_cnt < usb_spi_pkg::setup_len) begin
      setup_bytes[byte_cnt[2:0]] <= out_ep_data;
    end
    if (ifc.setup_end) begin
      load_addr <= '0;                // nothing to send by default
      load_len  <= '0;
      if (ifc.req_type == usb_spi_pkg::req_type_standard) begin
        if (ifc.request == usb_spi_pkg::req_get_descriptor) begin
          if (ifc.value[15:8] == usb_spi_pkg::desc_device) begin
            load_addr <= usb_spi_pkg::rom_addr_w'(usb_spi_pkg::dev_desc_addr);
            load_len  <= usb_spi_pkg::rom_addr_w'(usb_spi_pkg::dev_desc_len);
          end else if (ifc.value[15:8] == usb_spi_pkg::desc_config) begin
            load_addr <= usb_spi_pkg::rom_addr_w'(usb_spi_pkg::cfg_desc_addr);
            load_len  <= usb_spi_pkg::rom_addr_w'(usb_spi_pkg::cfg_desc_len);
          end
        end
        if (ifc.request == usb_spi_pkg::req_set_address) begin
          new_addr <= ifc.value[6:0];
        end
      end else if (ifc.req_type == usb_spi_pkg::req_type_vendor) begin
        if (ifc.request == usb_spi_pkg::vreq_spi_xfer && ifc.dir_in) begin
          load_len <= (ifc.length > 16'(usb_spi_pkg::spi_buf_depth)) ?
                      usb_spi_pkg::rom_addr_w'(usb_spi_pkg::spi_buf_depth) :
                      ifc.length[usb_spi_pkg::rom_addr_w-1:0];
        end
        if (ifc.request == usb_spi_pkg::vreq_spi_status) begin
          load_addr <= busy ? usb_spi_pkg::rom_addr_w'(usb_spi_pkg::busy_byte_addr) :
                              usb_spi_pkg::rom_addr_w'(usb_spi_pkg::idle_byte_addr);
          load_len  <= usb_spi_pkg::rom_addr_w'(1);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      byte_cnt    <= '0;
      addr_pend   <= 1'b0;
      dev_addr    <= '0;
      load        <= 1'b0;
      use_spi_buf <= 1'b0;
      stall       <= 1'b0;
    end else begin
      load  <= ifc.setup_end;
      stall <= ifc.setup_end && ifc.req_type == usb_spi_pkg::req_type_standard &&
               ifc.request == usb_spi_pkg::req_get_descriptor &&
               ifc.value[15:8] == usb_spi_pkg::desc_qualifier;  // no high-speed mode
      if (out_ep_setup && out_ep_data_valid && byte_cnt < usb_spi_pkg::setup_len) begin
        byte_cnt <= byte_cnt + 4'd1;
      end
      if (ifc.setup_end) begin
        use_spi_buf <= ifc.req_type == usb_spi_pkg::req_type_vendor &&
                       ifc.request == usb_spi_pkg::vreq_spi_xfer && ifc.dir_in;
        addr_pend   <= ifc.req_type == usb_spi_pkg::req_type_standard &&
                       ifc.request == usb_spi_pkg::req_set_address;
      end
      if (ifc.status_end) begin
        byte_cnt <= '0;               // ready for next setup
        if (addr_pend) begin
          dev_addr  <= new_addr;      // status went out on the old address
          addr_pend <= 1'b0;
        end
      end
    end
  end
endmodule

`default_nettype wire

// File: verilog/setup_if.sv
`timescale 1ns/10ps
`default_nettype none

interface setup_if;
  logic [1:0]  req_type;   // bmRequestType[6:5]
  logic        dir_in;     // device to host
  logic [7:0]  request;
  logic [15:0] value;
  logic [15:0] length;
  logic        setup_end;  // first cycle after setup stage
  logic        status_end; // handshake that closes the transfer
  logic        zlp;        // zero-length status packet
  usb_spi_pkg::ctrl_state_t state;

  modport src  (output req_type, dir_in, request, value, length,
                input  setup_end, status_end);
  modport fsm  (input  dir_in, length,
                output setup_end, status_end, zlp, state);
  modport sink (input  req_type, dir_in, request, value, length,
                input  setup_end, status_end, zlp, state);
endinterface

`default_nettype wire

// File: verilog/spi_bridge.sv
`timescale 1ns/10ps
`default_nettype none

module spi_bridge (
  input  logic                                          clk,
  input  logic                                          reset,
  setup_if.sink                                         ifc,
  input  logic                                          out_ep_data_valid,
  input  logic [7:0]                                    out_ep_data,
  input  logic                                          out_ep_setup,
  input  logic [$clog2(usb_spi_pkg::spi_buf_depth)-1:0] spi_rd_addr,
  output logic [7:0]                                    spi_rd_data,
  output logic                                          busy,
  input  logic                                          spi_miso,
  output logic                                          spi_mosi,
  output logic                                          spi_clk,
  output logic                                          spi_csn
);
  localparam int cw = usb_spi_pkg::spi_cnt_w;
  localparam int bw = $clog2(usb_spi_pkg::spi_buf_depth);

  logic [7:0]    out_buf [0:usb_spi_pkg::spi_buf_depth-1];  // host to spi
  logic [7:0]    in_buf  [0:usb_spi_pkg::spi_buf_depth-1];  // spi replies
  logic [cw-1:0] wr_ptr;
  logic [cw-1:0] spi_len;
  logic [cw-1:0] spi_sent;
  logic [3:0]    bit_cnt;     // bit 3 marks the idle cycle
  logic [7:0]    mosi_byte;
  logic [7:0]    miso_byte;
  logic [7:0]    miso_next;
  logic          xfer_start;
  logic          out_store;

  assign xfer_start = ifc.setup_end && ifc.req_type == usb_spi_pkg::req_type_vendor &&
                      ifc.request == usb_spi_pkg::vreq_spi_xfer && !ifc.dir_in;
  assign out_store  = ifc.state == usb_spi_pkg::data_out && out_ep_data_valid &&
                      !out_ep_setup && wr_ptr < cw'(usb_spi_pkg::spi_buf_depth);

  assign miso_next   = {miso_byte[6:0], spi_miso};  // msb arrives first
  assign spi_mosi    = mosi_byte[7];
  assign busy        = spi_sent != spi_len;
  assign spi_rd_data = in_buf[spi_rd_addr];

  always_ff @(posedge clk) begin
    if (out_store) out_buf[wr_ptr[bw-1:0]] <= out_ep_data;
    if (busy && wr_ptr != spi_sent && !bit_cnt[3]) begin
      if (spi_clk) begin            // falling edge, next mosi bit
        mosi_byte <= (bit_cnt[2:0] == 3'd0) ? out_buf[spi_sent[bw-1:0]] :
                                              {mosi_byte[6:0], 1'b0};
      end else begin                // rising edge, sample miso
        miso_byte <= miso_next;
        if (bit_cnt[2:0] == 3'd7) in_buf[spi_sent[bw-1:0]] <= miso_next;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // shift engine, mode 3, two clk cycles per bit
  //////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr   <= '0;
      spi_len  <= '0;
      spi_sent <= '0;
      bit_cnt  <= 4'd8;
      spi_clk  <= 1'b1;
      spi_csn  <= 1'b1;
    end else begin
      if (xfer_start) begin
        wr_ptr   <= '0;
        spi_sent <= '0;
        spi_len  <= (ifc.length > 16'(usb_spi_pkg::spi_buf_depth)) ?
                    cw'(usb_spi_pkg::spi_buf_depth) : ifc.length[cw-1:0];
      end else begin
        if (out_store) wr_ptr <= wr_ptr + 1'b1;
        if (!busy) begin
          spi_clk <= 1'b1;          // bus idle
          spi_csn <= 1'b1;
          bit_cnt <= 4'd8;
        end else begin
          spi_csn <= 1'b0;
          if (wr_ptr != spi_sent) begin  // else wait at byte boundary
            if (bit_cnt[3]) begin
              bit_cnt <= 4'd0;      // gap between csn and first edge
            end else begin
              if (!spi_clk) begin
                if (bit_cnt[2:0] == 3'd7) spi_sent <= spi_sent + 1'b1;
                bit_cnt[2:0] <= bit_cnt[2:0] + 3'd1;
              end
              spi_clk <= ~spi_clk;
            end
          end
        end
      end
    end
  end
endmodule

`default_nettype wire

// File: verilog/usb_spi_ctrl_ep.sv
`timescale 1ns/10ps
`default_nettype none

module usb_spi_ctrl_ep (
  input  logic       clk,
  input  logic       reset,
  output logic [6:0] dev_addr,
  input  logic       spi_miso,
  output logic       spi_mosi,
  output logic       spi_clk,
  output logic       spi_csn,
  // out endpoint
  output logic       out_ep_req,
  input  logic       out_ep_grant,
  input  logic       out_ep_data_avail,
  input  logic       out_ep_setup,
  output logic       out_ep_data_get,
  input  logic [7:0] out_ep_data,
  output logic       out_ep_stall,
  input  logic       out_ep_acked,
  // in endpoint
  output logic       in_ep_req,
  input  logic       in_ep_grant,
  input  logic       in_ep_data_free,
  output logic       in_ep_data_put,
  output logic [7:0] in_ep_data,
  output logic       in_ep_data_done,
  output logic       in_ep_stall,
  input  logic       in_ep_acked
);
  logic                                          out_ep_data_valid;
  logic                                          load, use_spi_buf, busy, all_sent;
  logic [usb_spi_pkg::rom_addr_w-1:0]            load_addr, load_len;
  logic [$clog2(usb_spi_pkg::spi_buf_depth)-1:0] spi_rd_addr;
  logic [7:0]                                    spi_rd_data;

  assign out_ep_req      = out_ep_data_avail;  // always take out data
  assign out_ep_data_get = out_ep_data_avail;
  assign out_ep_stall    = 1'b0;

  setup_if ifc ();

  setup_decoder u_dec (
    .clk, .reset, .out_ep_setup, .out_ep_data_valid, .out_ep_data, .busy,
    .ifc(ifc.src), .load, .load_addr, .load_len, .use_spi_buf,
    .stall(in_ep_stall), .dev_addr
  );

  ctrl_xfr_fsm u_fsm (
    .clk, .reset, .out_ep_data_avail, .out_ep_grant, .out_ep_setup, .out_ep_acked,
    .in_ep_acked, .all_sent, .stall(in_ep_stall), .ifc(ifc.fsm),
    .out_ep_data_valid, .in_ep_data_done
  );

  in_data_source u_src (
    .clk, .reset, .ifc(ifc.sink), .load, .load_addr, .load_len, .use_spi_buf,
    .in_ep_grant, .in_ep_data_free, .spi_rd_data, .spi_rd_addr, .all_sent,
    .in_ep_req, .in_ep_data_put, .in_ep_data
  );

  spi_bridge u_spi (
    .clk, .reset, .ifc(ifc.sink), .out_ep_data_valid, .out_ep_data, .out_ep_setup,
    .spi_rd_addr, .spi_rd_data, .busy, .spi_miso, .spi_mosi, .spi_clk, .spi_csn
  );
endmodule

`default_nettype wire

// File: verilog/usb_spi_pkg.sv
`default_nettype none

package usb_spi_pkg;

  typedef enum logic [2:0] {
    idle,
    setup,
    data_in,
    data_out,
    status_in,
    status_out
  } ctrl_state_t;

  localparam int setup_len      = 8;   // setup packet bytes
  localparam int spi_buf_depth  = 32;  // bytes per spi buffer
  localparam int spi_cnt_w      = 6;   // holds 0..32
  localparam int rom_depth      = 36;
  localparam int rom_addr_w     = 7;
  localparam int dev_desc_addr  = 0;
  localparam int dev_desc_len   = 18;
  localparam int cfg_desc_addr  = 18;  // config + interface block
  localparam int cfg_desc_len   = 18;
  localparam int busy_byte_addr = 1;   // rom holds 1 here
  localparam int idle_byte_addr = 5;   // rom holds 0 here

  localparam logic [7:0] req_get_descriptor = 8'h06;
  localparam logic [7:0] req_set_address    = 8'h05;
  localparam logic [7:0] vreq_spi_xfer      = 8'h00;
  localparam logic [7:0] vreq_spi_status    = 8'h01;

  localparam logic [1:0] req_type_standard = 2'd0;
  localparam logic [1:0] req_type_vendor   = 2'd2;

  localparam logic [7:0] desc_device    = 8'd1;
  localparam logic [7:0] desc_config    = 8'd2;
  localparam logic [7:0] desc_qualifier = 8'd6;

  // descriptor rom, device descriptor then configuration + interface
  function automatic logic [7:0] rom_byte(input logic [rom_addr_w-1:0] addr);
    case (addr)
      0:       rom_byte = 8'd18;  // bLength
      1:       rom_byte = 8'd1;   // device type
      3:       rom_byte = 8'h02;  // usb 2.00
      4:       rom_byte = 8'hff;  // vendor class
      7:       rom_byte = 8'd32;  // ep0 max packet
      8:       rom_byte = 8'hc0;  // idVendor lo
      9:       rom_byte = 8'h16;
      10:      rom_byte = 8'hdc;  // idProduct lo
      11:      rom_byte = 8'h05;
      12:      rom_byte = 8'h01;  // bcdDevice minor
      17:      rom_byte = 8'd1;   // one configuration
      18:      rom_byte = 8'd9;   // config bLength
      19:      rom_byte = 8'd2;
      20:      rom_byte = 8'd18;  // wTotalLength lo
      22:      rom_byte = 8'd1;   // interfaces
      23:      rom_byte = 8'd1;   // config value
      25:      rom_byte = 8'hc0;  // self powered
      26:      rom_byte = 8'd250; // max power
      27:      rom_byte = 8'd9;   // interface bLength
      28:      rom_byte = 8'd4;
      default: rom_byte = 8'h00; // zero fields and past the end
    endcase
  endfunction

endpackage

`default_nettype wire
